/* Makefile */
# Verilator flow for the cartridge path testbench

VERILATOR  ?= verilator
TOP        ?= tb_nes_cart
LINT_TOP   ?= nes_cart_top
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/1ps
PASS_MSG   := Test OK

SRCS := $(wildcard logic/*.sv logic/*.svh dv/*.sv dv/*.svh)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/nes_cart_model.svh */
/*
 * Reference model for the cartridge path testbench. Header vectors hold file
 * byte i at index i. Included inside the testbench module.
 */
`ifndef NES_CART_MODEL_SVH
`define NES_CART_MODEL_SVH

// Count pages up in powers of two until they fit
function automatic logic [2:0] size_code_model(input logic [7:0] pages);
	int k;
	k = 0;
	while (k < 7 && (1 << k) < int'(pages))
		k++;
	return k[2:0];
endfunction

function automatic logic model_header_ok(input logic [15:0][7:0] h);
	logic magic;
	magic = (h[0] == `NES_MAGIC0) && (h[1] == `NES_MAGIC1) &&
		(h[2] == `NES_MAGIC2) && (h[3] == `NES_MAGIC3);
	return magic && !h[6][2]; // Trainer images are refused
endfunction

function automatic nes_cart_pkg::mapper_flags_t model_flags(input logic [15:0][7:0] h,
		input logic inv);
	nes_cart_pkg::mapper_flags_t m;
	logic nes20;
	logic dirty;
	nes20 = h[7][3] && !h[7][2];
	dirty = 1'b0;
	if (!nes20) begin
		if (h[9] > 8'd1)
			dirty = 1'b1;   // Bits 7:1 of byte 9
		for (int i = 10; i < 16; i++) begin
			if (h[i] != 8'd0)
				dirty = 1'b1;
		end
	end
	m.mapper = {dirty ? 4'h0 : h[7][7:4], h[6][7:4]};
	m.prg_size = size_code_model(h[4]);
	m.chr_size = size_code_model(h[5]);
	m.mirroring = h[6][0] ^ inv;
	m.chr_ram = (h[5] == 8'd0);
	m.four_screen = h[6][3];
	m.submapper = nes20 ? h[8] : 8'h00;
	return m;
endfunction

// Header, then PRG and CHR, or just the header when it is refused
function automatic int expected_write_count(input logic [15:0][7:0] h);
	if (!model_header_ok(h))
		return `NES_HDR_BYTES;
	return `NES_HDR_BYTES + (int'(h[4]) << `NES_PRG_PAGE_SHIFT) +
		(int'(h[5]) << `NES_CHR_PAGE_SHIFT);
endfunction

function automatic logic [`NES_MEM_ADDR_W-1:0] expected_addr(input int idx,
		input logic [15:0][7:0] h);
	int prg_len;
	int a;
	prg_len = int'(h[4]) << `NES_PRG_PAGE_SHIFT;
	if (idx < `NES_HDR_BYTES)
		a = idx;
	else if (idx - `NES_HDR_BYTES < prg_len)
		a = idx - `NES_HDR_BYTES;
	else
		a = int'(`NES_CHR_BASE) + idx - `NES_HDR_BYTES - prg_len;
	return a[`NES_MEM_ADDR_W-1:0];
endfunction

// Bit 0 is read first
function automatic logic [23:0] port_stream(input int port, input nes_cart_pkg::pad_set_t p,
		input logic tap, input logic swap);
	logic [7:0] own;
	logic [7:0] extra;
	logic [7:0] sig;
	own = ((port == 0) ^ swap) ? p.pad_a : p.pad_b;
	extra = !tap ? 8'h00 : ((port == 0) ? p.pad_c : p.pad_d);
	sig = !tap ? 8'h00 : ((port == 0) ? `NES_TAP_SIG_P1 : `NES_TAP_SIG_P2);
	return {sig, extra, own};
endfunction

`endif

/* dv/tb_nes_cart.sv */
/*
 * Testbench for the cartridge path top. ROM images use 1 to 2 PRG pages and
 * 0 to 2 CHR pages to bound run time. Every wait has its own cycle limit.
 */
`timescale 1ns/1ps
`include "nes_consts.svh"

module tb_nes_cart;

	`include "nes_cart_model.svh"

	logic clk;
	logic reset;
	logic [7:0] in_byte;
	logic in_valid;
	logic in_ready;
	logic downloading;
	logic invert_mirroring;
	nes_cart_pkg::mem_write_t mem_req;
	logic mem_wr;
	nes_cart_pkg::mapper_flags_t mapper_flags;
	logic busy;
	logic done;
	logic fail;
	nes_cart_pkg::pad_set_t pads;
	logic multitap;
	logic joy_swap;
	logic joy_strobe;
	logic [1:0] joy_clk;
	logic [1:0] joy_data;

	int errors = 0;
	int checks = 0;
	int tests = 0;
	int cycle = 0;
	int last_wr = -100;
	logic busy_seen = 1'b0;  // busy was high at some point of the load
	logic [7:0] file_q[$];   // Whole download image
	nes_cart_pkg::mem_write_t seen_q[$];
	logic [15:0][7:0] hdr;

	nes_cart_top i_dut (.*);

	always #50 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	// Collect memory writes and watch the slot spacing and busy
	always @(negedge clk) begin
		if (!reset && busy === 1'b1)
			busy_seen = 1'b1;
		if (!reset && mem_wr === 1'b1) begin
			check_value("mem_wr gap of 4 cycles", 64'(cycle - last_wr >= 4), 64'd1);
			last_wr = cycle;
			seen_q.push_back(mem_req);
		end
	end

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic note_timeout(input string what);
		errors++;
		$display("timeout at %0t while waiting for %s", $time, what);
	endtask

	task automatic finish_test(input string name, input int start_err);
		tests++;
		$display("test %s finished with %0d errors", name, errors - start_err);
	endtask

	task automatic apply_reset;
		@(posedge clk);
		#1;
		reset = 1'b1;
		in_valid = 1'b0;
		downloading = 1'b0;
		joy_strobe = 1'b0;
		joy_clk = 2'b11;   // Port clocks idle high
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		seen_q.delete();
		last_wr = -100;
		busy_seen = 1'b0;
	endtask

	// Kinds: 0 clean iNES, 1 NES 2.0, 2 dirty, 3 bad magic, 4 trainer
	task automatic build_file(input int kind);
		int extra;
		file_q.delete();
		hdr[0] = `NES_MAGIC0;
		hdr[1] = `NES_MAGIC1;
		hdr[2] = `NES_MAGIC2;
		hdr[3] = `NES_MAGIC3;
		hdr[4] = 8'($urandom_range(2, 1));
		hdr[5] = 8'($urandom_range(2, 0));
		hdr[6] = 8'($urandom) & 8'hFB;
		hdr[7] = 8'($urandom);
		for (int i = 8; i < 16; i++)
			hdr[i] = 8'($urandom);
		case (kind)
			0: begin
				hdr[7][3:2] = 2'b00;
				for (int i = 8; i < 16; i++)
					hdr[i] = 8'h00;
			end
			1: hdr[7][3:2] = 2'b10;
			2: begin
				if (hdr[7][3:2] == 2'b10)
					hdr[7][3] = 1'b0;
				hdr[12][0] = 1'b1; // Junk in the tail
			end
			3: hdr[4'($urandom_range(3, 0))] ^= 8'h20;
			default: hdr[6][2] = 1'b1;
		endcase
		for (int i = 0; i < 16; i++)
			file_q.push_back(hdr[i]);
		extra = expected_write_count(hdr) - `NES_HDR_BYTES;
		if (kind >= 3)
			extra = 8;   // Trailing bytes that must not be written
		repeat (extra) file_q.push_back(8'($urandom));
	endtask

	task automatic send_bytes(input logic continuous, output logic ok);
		int idx;
		int guard;
		idx = 0;
		guard = 0;
		while (idx < file_q.size() && guard < file_q.size() * 8 + 100) begin
			@(posedge clk);
			#1;
			in_valid = continuous || ($urandom_range(2, 0) != 0);
			in_byte = file_q[idx];
			@(negedge clk);
			if (in_valid && in_ready)
				idx++;   // Transfers on the coming edge
			guard++;
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		ok = (idx == file_q.size());
		if (!ok)
			note_timeout("in_ready during the download");
	endtask

	task automatic wait_for_done(output logic ok);
		ok = 1'b0;
		for (int cnt = 0; cnt < 200 && !ok; cnt++) begin
			@(negedge clk);
			ok = (done === 1'b1);
		end
		if (!ok)
			note_timeout("done");
	endtask

	task automatic wait_for_writes(input int count, output logic ok);
		for (int cnt = 0; cnt < 40 && seen_q.size() < count; cnt++)
			@(negedge clk);
		ok = (seen_q.size() >= count);
		if (!ok)
			note_timeout("the last mem_wr");
		repeat (8) @(negedge clk); // Room for stray writes to show up
	endtask

	task automatic compare_writes(input int count);
		int first_err;
		first_err = errors;
		check_value("mem_wr count", 64'(seen_q.size()), 64'(count));
		for (int i = 0; i < count && i < seen_q.size() && errors == first_err; i++) begin
			check_value($sformatf("mem_req.addr[%0d]", i), 64'(seen_q[i].addr),
				64'(expected_addr(i, hdr)));
			check_value($sformatf("mem_req.data[%0d]", i), 64'(seen_q[i].data),
				64'(file_q[i]));
		end
	endtask

	task automatic run_load(input string name, input int kind, input logic continuous);
		int start_err;
		int count;
		logic ok;
		logic hdr_ok;
		start_err = errors;
		apply_reset();
		build_file(kind);
		hdr_ok = model_header_ok(hdr);
		count = expected_write_count(hdr);
		invert_mirroring = 1'($urandom_range(1, 0));
		downloading = 1'b1;
		send_bytes(continuous, ok);
		if (ok)
			wait_for_done(ok);
		if (ok) begin
			check_value("fail", 64'(fail), 64'(!hdr_ok));
			check_value("busy", 64'(busy), 64'd0);
			check_value("busy seen during load", 64'(busy_seen), 64'(hdr_ok));
			if (hdr_ok)
				check_value("mapper_flags", 64'(mapper_flags),
					64'(model_flags(hdr, invert_mirroring)));
			wait_for_writes(count, ok);
		end
		if (ok)
			compare_writes(count);
		downloading = 1'b0;
		finish_test(name, start_err);
	endtask

	task automatic run_joypad(input string name);
		int start_err;
		logic [23:0] exp0;
		logic [23:0] exp1;
		start_err = errors;
		@(posedge clk);
		#1;
		pads = $urandom;
		multitap = 1'($urandom_range(1, 0));
		joy_swap = 1'($urandom_range(1, 0));
		joy_strobe = 1'b1;
		@(posedge clk);
		#1;
		joy_strobe = 1'b0;
		exp0 = port_stream(0, pads, multitap, joy_swap);
		exp1 = port_stream(1, pads, multitap, joy_swap);
		for (int i = 0; i < 24; i++) begin
			@(negedge clk);
			check_value($sformatf("joy_data[0] bit %0d", i), 64'(joy_data[0]), 64'(exp0[i]));
			check_value($sformatf("joy_data[1] bit %0d", i), 64'(joy_data[1]), 64'(exp1[i]));
			@(posedge clk);
			#1;
			joy_clk = 2'b00;
			@(posedge clk);
			#1;
			joy_clk = 2'b11;
		end
		@(negedge clk);
		check_value("joy_data after 24 bits", 64'(joy_data), 64'd0);
		finish_test(name, start_err);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		in_byte = 8'h00;
		in_valid = 1'b0;
		downloading = 1'b0;
		invert_mirroring = 1'b0;
		pads = '0;
		multitap = 1'b0;
		joy_swap = 1'b0;
		joy_strobe = 1'b0;
		joy_clk = 2'b11;
		void'($urandom(32'h5573_271b));

		apply_reset();
		@(negedge clk);
		check_value("busy", 64'(busy), 64'd0);
		check_value("done", 64'(done), 64'd0);
		check_value("fail", 64'(fail), 64'd0);
		check_value("mem_wr", 64'(mem_wr), 64'd0);
		check_value("in_ready", 64'(in_ready), 64'd1);
		finish_test("reset_state", 0);

		for (int t = 0; t < 3; t++)
			run_load($sformatf("load_kind_%0d", t), t, 1'b0);
		run_load("back_pressure", int'($urandom_range(2, 0)), 1'b1);
		run_load("bad_magic", 3, 1'b0);
		run_load("trainer_set", 4, 1'b0);
		for (int t = 0; t < 4; t++)
			run_joypad($sformatf("joypad_%0d", t));

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+logic
+incdir+dv
logic/nes_cart_pkg.sv
logic/ines_header_decode.sv
logic/rom_loader.sv
logic/cart_write_slot.sv
logic/joypad_ports.sv
logic/nes_cart_top.sv
dv/tb_nes_cart.sv

/* logic/cart_write_slot.sv */
/*
 * One-entry hold buffer in front of the core's memory slot. A write is
 * released as a one-cycle strobe on the slot phase, so throughput is at most
 * one byte every four clocks. wr_ready is low while a write is held.
 */
`timescale 1ns/1ps
`include "nes_consts.svh"

module cart_write_slot (
	input  logic                     clk,
	input  logic                     reset,
	input  nes_cart_pkg::mem_write_t wr_req,
	input  logic                     wr_valid,
	output logic                     wr_ready,
	output nes_cart_pkg::mem_write_t mem_req,
	output logic                     mem_wr
);

	localparam logic [1:0] SLOT_PHASE = 2'(`NES_SLOT_PHASE);

	logic [1:0] slot;  // Stands in for the core's clock enable
	logic held;
	logic at_slot;
	nes_cart_pkg::mem_write_t held_req;

	assign at_slot  = (slot == SLOT_PHASE);
	assign wr_ready = !held;

	// Strobe lasts exactly the slot cycle
	assign mem_wr  = held && at_slot;
	assign mem_req = held_req;

	always_ff @(posedge clk) begin
		if (reset) begin
			slot <= '0;
			held <= 1'b0;
		end else begin
			slot <= slot + 1'b1;
			if (wr_valid && wr_ready)
				held <= 1'b1;
			else if (mem_wr)
				held <= 1'b0; // Released on this edge
		end
	end

	always_ff @(posedge clk) begin
		if (wr_valid && wr_ready)
			held_req <= wr_req;
	end

endmodule

/* logic/ines_header_decode.sv */
/*
 * Pure decode of a captured iNES header. Outputs are only meaningful once
 * all 16 bytes are in. Trainers are not supported and count as a bad header.
 */
`timescale 1ns/1ps
`include "nes_consts.svh"

module ines_header_decode (
	input  nes_cart_pkg::nes_header_u   header,
	input  logic                        invert_mirroring,
	output logic                        header_ok,
	output nes_cart_pkg::mapper_flags_t mapper_flags
);

	localparam logic [31:0] MAGIC = {`NES_MAGIC3, `NES_MAGIC2, `NES_MAGIC1, `NES_MAGIC0};

	logic trainer;
	logic is_nes20;
	logic is_dirty;
	logic magic_ok;

	// Smallest k with pages <= 2**k, saturating at 7
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd7;
		for (int k = 6; k >= 0; k--) begin
			if ({1'b0, pages} <= (9'd1 << k))
				code = 3'(k);
		end
		return code;
	endfunction

	assign magic_ok = (header.f.magic == MAGIC);
	assign trainer  = header.f.flags6[2];
	assign header_ok = magic_ok && !trainer;

	// NES 2.0 signature in flags 7
	assign is_nes20 = (header.f.flags7[3:2] == 2'b10);

	// Old dumps often carry junk in the tail bytes
	assign is_dirty = !is_nes20 &&
		((header.bytes[9][7:1] != 7'd0) || (header.bytes[15:10] != '0));

	assign mapper_flags.mapper = {
		is_dirty ? 4'h0 : header.f.flags7[7:4], // Upper nibble untrusted in dirty headers
		header.f.flags6[7:4]
	};
	assign mapper_flags.prg_size = size_code(header.f.prg_pages);
	assign mapper_flags.chr_size = size_code(header.f.chr_pages);
	assign mapper_flags.mirroring = header.f.flags6[0] ^ invert_mirroring;
	assign mapper_flags.chr_ram = (header.f.chr_pages == 8'd0); // No CHR ROM means CHR RAM
	assign mapper_flags.four_screen = header.f.flags6[3];
	assign mapper_flags.submapper = is_nes20 ? header.f.submapper : 8'h00;

endmodule

/* logic/joypad_ports.sv */
/*
 * Two controller ports with serial readout. Strobe wins over a port clock
 * edge in the same cycle. Multitap adds pads C and D plus the signature byte
 * and all further bits read as zero.
 */
`timescale 1ns/1ps
`include "nes_consts.svh"

module joypad_ports (
	input  logic                   clk,
	input  logic                   reset,
	input  nes_cart_pkg::pad_set_t pads,
	input  logic                   multitap,
	input  logic                   joy_swap,
	input  logic                   joy_strobe,
	input  logic [1:0]             joy_clk,
	output logic [1:0]             joy_data
);

	logic [1:0][`NES_JOY_SHIFT_W-1:0] shift_q;
	logic [1:0][`NES_JOY_SHIFT_W-1:0] load_val;
	logic [1:0] joy_clk_q;  // Previous port clock levels
	logic [1:0] clk_fall;
	logic [7:0] first_pad;
	logic [7:0] second_pad;
	logic [15:0] tap_p1;
	logic [15:0] tap_p2;

	assign first_pad  = joy_swap ? pads.pad_b : pads.pad_a;
	assign second_pad = joy_swap ? pads.pad_a : pads.pad_b;

	// Extra pad then signature when the tap is plugged in
	assign tap_p1 = multitap ? {`NES_TAP_SIG_P1, pads.pad_c} : 16'h0000;
	assign tap_p2 = multitap ? {`NES_TAP_SIG_P2, pads.pad_d} : 16'h0000;

	assign load_val[0] = {tap_p1, first_pad};
	assign load_val[1] = {tap_p2, second_pad};

	assign clk_fall = joy_clk_q & ~joy_clk;

	always_ff @(posedge clk) begin
		if (reset) begin
			shift_q   <= '0;
			joy_clk_q <= '0;
		end else begin
			joy_clk_q <= joy_clk;
			for (int n = 0; n < 2; n++) begin
				if (joy_strobe)
					shift_q[n] <= load_val[n];
				else if (clk_fall[n])
					shift_q[n] <= {1'b0, shift_q[n][`NES_JOY_SHIFT_W-1:1]}; // Zero fill
			end
		end
	end

	assign joy_data = {shift_q[1][0], shift_q[0][0]};

endmodule

/* logic/nes_cart_pkg.sv */
/*
 * Shared cartridge types. The header union keeps byte 0 in the low bits,
 * so bytes[i] is byte i of the file. Mapper flag layout follows the core's
 * 25-bit flag word with the mapper number in the low byte.
 */
`include "nes_consts.svh"

package nes_cart_pkg;

	// Captured iNES header seen as raw bytes or as named fields
	typedef union packed {
		logic [`NES_HDR_BYTES-1:0][7:0] bytes;
		struct packed {
			logic [55:0] rest;      // Bytes 9 to 15 with byte 9 lowest
			logic [7:0]  submapper; // Byte 8
			logic [7:0]  flags7;
			logic [7:0]  flags6;
			logic [7:0]  chr_pages; // 8 KB units
			logic [7:0]  prg_pages; // 16 KB units
			logic [31:0] magic;     // Byte 0 lowest
		} f;
	} nes_header_u;

	typedef struct packed {
		logic [7:0] submapper;   // NES 2.0 only
		logic       four_screen;
		logic       chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

	// One byte bound for cartridge memory
	typedef struct packed {
		logic [`NES_MEM_ADDR_W-1:0] addr;
		logic [7:0]                 data;
	} mem_write_t;

	// Buttons in NES order with A in bit 0 and Right in bit 7
	typedef struct packed {
		logic [7:0] pad_a;
		logic [7:0] pad_b;
		logic [7:0] pad_c;
		logic [7:0] pad_d;
	} pad_set_t;

endpackage

/* logic/nes_cart_top.sv */
/*
 * Cartridge path top. in_ready comes straight from the write slot buffer,
 * so the stream is throttled to the core's memory slot. done may lead the
 * last mem_wr by up to four clocks.
 */
`timescale 1ns/1ps

module nes_cart_top (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [7:0]                  in_byte,
	input  logic                        in_valid,
	output logic                        in_ready,
	input  logic                        downloading,
	input  logic                        invert_mirroring,
	output nes_cart_pkg::mem_write_t    mem_req,
	output logic                        mem_wr,
	output nes_cart_pkg::mapper_flags_t mapper_flags,
	output logic                        busy,
	output logic                        done,
	output logic                        fail,
	input  nes_cart_pkg::pad_set_t      pads,
	input  logic                        multitap,
	input  logic                        joy_swap,
	input  logic                        joy_strobe,
	input  logic [1:0]                  joy_clk,
	output logic [1:0]                  joy_data
);

	nes_cart_pkg::nes_header_u   header;
	nes_cart_pkg::mapper_flags_t decoded_flags;
	nes_cart_pkg::mem_write_t    wr_req;
	logic header_ok;
	logic wr_valid;

	rom_loader u_loader (
		.clk(clk),
		.reset(reset),
		.in_byte(in_byte),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.downloading(downloading),
		.invert_mirroring(invert_mirroring),
		.header_ok(header_ok),
		.decoded_flags(decoded_flags),
		.header(header),
		.wr_req(wr_req),
		.wr_valid(wr_valid),
		.mapper_flags(mapper_flags),
		.busy(busy),
		.done(done),
		.fail(fail)
	);

	ines_header_decode u_decode (
		.header(header),
		.invert_mirroring(invert_mirroring),
		.header_ok(header_ok),
		.mapper_flags(decoded_flags)
	);

	cart_write_slot u_slot (
		.clk(clk),
		.reset(reset),
		.wr_req(wr_req),
		.wr_valid(wr_valid),
		.wr_ready(in_ready), // Loader takes a byte only when the buffer is free
		.mem_req(mem_req),
		.mem_wr(mem_wr)
	);

	joypad_ports u_joy (
		.clk(clk),
		.reset(reset),
		.pads(pads),
		.multitap(multitap),
		.joy_swap(joy_swap),
		.joy_strobe(joy_strobe),
		.joy_clk(joy_clk),
		.joy_data(joy_data)
	);

endmodule

/* logic/nes_consts.svh */
/*
 * Cartridge path constants. Page shifts assume the iNES page sizes of 16 KB PRG
 * and 8 KB CHR. The memory map keeps CHR in the upper half of a 4 MB space.
 */
`ifndef NES_CONSTS_SVH
`define NES_CONSTS_SVH

// iNES header
`define NES_HDR_BYTES 16
`define NES_MAGIC0 8'h4E // 'N'
`define NES_MAGIC1 8'h45 // 'E'
`define NES_MAGIC2 8'h53 // 'S'
`define NES_MAGIC3 8'h1A

// Page sizes as shift amounts
`define NES_PRG_PAGE_SHIFT 14
`define NES_CHR_PAGE_SHIFT 13

// Memory side
`define NES_MEM_ADDR_W 22
`define NES_CHR_BASE 22'h20_0000 // Top address bit set
`define NES_BYTES_LEFT_W 22

// Core takes a memory write on one phase of its four-phase enable
`define NES_SLOT_PHASE 3

// Controller ports
`define NES_JOY_SHIFT_W 24
`define NES_TAP_SIG_P1 8'h08
`define NES_TAP_SIG_P2 8'h04

`endif

/* logic/rom_loader.sv */
/*
 * iNES loader. Header bytes are also written to memory at 0 to 15 before PRG
 * overwrites them. Trainer and FDS images are rejected. After done or fail
 * further bytes are accepted and dropped until reset.
 */
`timescale 1ns/1ps
`include "nes_consts.svh"

module rom_loader (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [7:0]                  in_byte,
	input  logic                        in_valid,
	input  logic                        in_ready,
	input  logic                        downloading,
	input  logic                        invert_mirroring,
	input  logic                        header_ok,
	input  nes_cart_pkg::mapper_flags_t decoded_flags,
	output nes_cart_pkg::nes_header_u   header,
	output nes_cart_pkg::mem_write_t    wr_req,
	output logic                        wr_valid,
	output nes_cart_pkg::mapper_flags_t mapper_flags,
	output logic                        busy,
	output logic                        done,
	output logic                        fail
);

	localparam logic [3:0] HDR_LAST = 4'(`NES_HDR_BYTES - 1);
	localparam logic [`NES_BYTES_LEFT_W-1:0] LAST_LEFT = 1;

	typedef enum logic [2:0] {
		ST_HEADER,
		ST_PRG,
		ST_CHR,
		ST_ERROR,
		ST_DONE
	} state_t;

	state_t state, state_next;
	logic [3:0] hdr_cnt;
	logic hdr_full;  // All header bytes captured and waiting for the check
	logic [`NES_MEM_ADDR_W-1:0] addr;
	logic [`NES_BYTES_LEFT_W-1:0] bytes_left;
	logic [`NES_BYTES_LEFT_W-1:0] prg_bytes;
	logic [`NES_BYTES_LEFT_W-1:0] chr_bytes;
	logic take;
	logic hdr_take;
	logic seg_take;

	assign prg_bytes = {{(`NES_BYTES_LEFT_W-8){1'b0}}, header.f.prg_pages} << `NES_PRG_PAGE_SHIFT;
	assign chr_bytes = {{(`NES_BYTES_LEFT_W-8){1'b0}}, header.f.chr_pages} << `NES_CHR_PAGE_SHIFT;

	// Stream bytes outside a download are ignored
	assign take     = in_valid && in_ready && downloading;
	assign hdr_take = take && (state == ST_HEADER) && !hdr_full;
	assign seg_take = take && ((state == ST_PRG) || (state == ST_CHR));

	assign wr_valid    = hdr_take || seg_take;
	assign wr_req.addr = addr;
	assign wr_req.data = in_byte;

	// Empty segments are skipped so a segment state never sits at zero bytes
	always_comb begin
		state_next = state;
		case (state)
			ST_HEADER: begin
				if (hdr_full) begin
					if (!header_ok)
						state_next = ST_ERROR;
					else if (prg_bytes != '0)
						state_next = ST_PRG;
					else
						state_next = (chr_bytes != '0) ? ST_CHR : ST_DONE;
				end
			end
			ST_PRG: begin
				if (seg_take && bytes_left == LAST_LEFT)
					state_next = (chr_bytes != '0) ? ST_CHR : ST_DONE;
			end
			ST_CHR: begin
				if (seg_take && bytes_left == LAST_LEFT)
					state_next = ST_DONE;
			end
			default: state_next = state; // Error and done hold until reset
		endcase
	end

	always_ff @(posedge clk) begin
		if (hdr_take)
			header.bytes[hdr_cnt] <= in_byte;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state        <= ST_HEADER;
			hdr_cnt      <= '0;
			hdr_full     <= 1'b0;
			addr         <= '0;
			bytes_left   <= '0;
			busy         <= 1'b0;
			done         <= 1'b0;
			fail         <= 1'b0;
			mapper_flags <= '0;
		end else begin
			state <= state_next;
			busy  <= (state_next == ST_PRG) || (state_next == ST_CHR);
			done  <= (state_next == ST_DONE) || (state_next == ST_ERROR);
			fail  <= (state_next == ST_ERROR);

			if (hdr_take) begin
				hdr_cnt  <= hdr_cnt + 1'b1;
				hdr_full <= (hdr_cnt == HDR_LAST);
				addr     <= addr + 1'b1;
			end else if (seg_take) begin
				addr       <= addr + 1'b1;
				bytes_left <= bytes_left - 1'b1;
			end

			// Segment entry overrides the running address
			if (state_next == ST_PRG && state != ST_PRG) begin
				addr       <= '0;
				bytes_left <= prg_bytes;
			end else if (state_next == ST_CHR && state != ST_CHR) begin
				addr       <= `NES_CHR_BASE;
				bytes_left <= chr_bytes;
			end

			if (state_next == ST_DONE && state != ST_DONE)
				mapper_flags <= decoded_flags;
			else if (state == ST_DONE)
				mapper_flags.mirroring <= header.f.flags6[0] ^ invert_mirroring; // Follows the option after load
		end
	end

endmodule
